//--- hw/cart_load_defines.svh
`ifndef CART_LOAD_DEFINES_SVH
`define CART_LOAD_DEFINES_SVH

// loader word and byte address widths
`define CL_ADDR_W 25
`define CL_DATA_W 16

////////////////////////////////////////////////////////////
// cartridge header byte addresses
////////////////////////////////////////////////////////////

// product id is spread over five words
`define HDR_ID_ADDR_0 25'h182
`define HDR_ID_ADDR_1 25'h184
`define HDR_ID_ADDR_2 25'h186
`define HDR_ID_ADDR_3 25'h188
`define HDR_ID_ADDR_4 25'h18A
// id is complete once this word arrives
`define HDR_ID_DECODE_ADDR 25'h18C
// region letters
`define HDR_REGION_ADDR_0 25'h1F0
`define HDR_REGION_ADDR_1 25'h1F2
// first word past the header
`define HDR_END_ADDR 25'h200

// quirk flags and cheat record
`define QUIRK_W 8
`define CHEAT_W 129

// light gun sensor delay in pixel clocks
`define GUN_DELAY_W 8
`define GUN_DELAY_DEFAULT 8'd44
`define GUN_DELAY_BODY_COUNT 8'd100
`define GUN_DELAY_LETHAL_1 8'd52
`define GUN_DELAY_LETHAL_2 8'd30

////////////////////////////////////////////////////////////
// product ids as eight ascii chars padded with spaces
////////////////////////////////////////////////////////////
`define ID_NFL_QB_CLUB "T-081276"
`define ID_NBA_JAM_TE "T-81406 "
`define ID_HOLYFIELD "MK-1215 "
`define ID_WONDER_BOY "G-4060  "
`define ID_PUGGSY "T-113016"
`define ID_CLUE "T-89016 "
`define ID_PIER_SOLAR "T-574023"
`define ID_VIRTUA_RACING "MK-1229 "
`define ID_HELLFIRE "T-35036 "
`define ID_KANZUME "T-68???-"
`define ID_BODY_COUNT "MK-1533 "
`define ID_LETHAL_1 "T-95096-"
`define ID_LETHAL_2 "T-95136-"

`endif

//--- hw/cart_load_pkg.sv
package cart_load_pkg;

	////////////////////////////////////////////////////////////
	// load bridge
	////////////////////////////////////////////////////////////

	// idle takes a word, wait_ack holds until the memory catches up
	typedef enum logic {
		ST_IDLE     = 1'b0,
		ST_WAIT_ACK = 1'b1
	} bridge_state_e;

	////////////////////////////////////////////////////////////
	// cartridge quirks
	////////////////////////////////////////////////////////////

	// bit positions inside the quirk flag vector
	typedef enum logic [2:0] {
		QK_SRAM   = 3'd0,
		QK_EEPROM = 3'd1,
		QK_FIFO   = 3'd2,
		QK_NORAM  = 3'd3,
		QK_PIER   = 3'd4,
		QK_SVP    = 3'd5,
		QK_FMBUSY = 3'd6,
		QK_SCHAN  = 3'd7
	} quirk_idx_e;

	// light gun reload style
	typedef enum logic {
		GUN_MENACER   = 1'b0,
		GUN_JUSTIFIER = 1'b1
	} gun_type_e;

endpackage

//--- hw/rom_load_bridge.sv
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module rom_load_bridge
	import cart_load_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	// loader side
	input  logic                   load_active,
	input  logic                   load_is_code,
	input  logic                   load_valid,
	output logic                   load_ready,
	input  logic [`CL_ADDR_W-1:0]  load_addr,
	input  logic [`CL_DATA_W-1:0]  load_data,
	// memory write port, toggle handshake
	output logic                   mem_req,
	input  logic                   mem_ack,
	output logic [`CL_ADDR_W-2:0]  mem_addr,
	output logic [`CL_DATA_W-1:0]  mem_data,
	// snoop bus to the header and cheat blocks
	output logic                   cart_stb,
	output logic                   code_stb,
	output logic [`CL_ADDR_W-1:0]  word_addr,
	output logic [`CL_DATA_W-1:0]  word_data,
	output logic                   cart_begin,
	output logic                   cart_end
);

	bridge_state_e state;
	logic          take;
	logic          take_live;
	logic          cart_now;
	logic          cart_q;

	// handshake on the loader side
	assign take = load_valid & load_ready;
	// words offered outside a load are swallowed
	assign take_live = take & load_active;
	// a cartridge load is active with kind image
	assign cart_now = load_active & ~load_is_code;

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			load_ready <= 1'b1;
			mem_req    <= 1'b0;
			cart_stb   <= 1'b0;
			code_stb   <= 1'b0;
			cart_q     <= 1'b0;
			cart_begin <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			// strobes are single cycle
			cart_stb <= 1'b0;
			code_stb <= 1'b0;
			// load edges
			cart_q     <= cart_now;
			cart_begin <= cart_now & ~cart_q;
			cart_end   <= ~cart_now & cart_q;
			case (state)
				ST_IDLE: begin
					if (take_live) begin
						if (load_is_code) begin
							// cheat words never reach memory
							code_stb <= 1'b1;
						end else begin
							mem_req    <= ~mem_req;
							cart_stb   <= 1'b1;
							load_ready <= 1'b0;
							state      <= ST_WAIT_ACK;
						end
					end
				end
				ST_WAIT_ACK: begin
					// write done once ack has followed the request
					if (mem_req == mem_ack) begin
						load_ready <= 1'b1;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// word and memory payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (take_live) begin
			word_addr <= load_addr;
			word_data <= load_data;
			if (!load_is_code) begin
				// memory is word addressed, bytes go in swapped
				mem_addr <= load_addr[`CL_ADDR_W-1:1];
				mem_data <= {load_data[7:0], load_data[15:8]};
			end
		end
	end

	// the request only moves once the previous write is complete
	a_req_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(mem_req != mem_ack) |=> $stable(mem_req));

endmodule

//--- hw/header_region_scan.sv
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module header_region_scan (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   cart_stb,
	input  logic                   cart_begin,
	input  logic                   cart_end,
	input  logic [`CL_ADDR_W-1:0]  word_addr,
	input  logic [`CL_DATA_W-1:0]  word_data,
	output logic                   hdr_j,
	output logic                   hdr_u,
	output logic                   hdr_e,
	output logic                   hdr_ready
);

	// classify one region byte into j, u, e hit bits
	function automatic logic [2:0] region_class(input logic [7:0] ch);
		if (ch == "J")
			return 3'b100;
		else if (ch == "U")
			return 3'b010;
		// any other printable code counts as europe
		else if (ch >= "0" && ch <= "Z")
			return 3'b001;
		else
			return 3'b000;
	endfunction

	logic       at_r0;
	logic       at_r1;
	logic [2:0] lo_hit;
	logic [2:0] hi_hit;
	logic [2:0] hit;

	assign at_r0 = (word_addr == `HDR_REGION_ADDR_0);
	assign at_r1 = (word_addr == `HDR_REGION_ADDR_1);
	// low byte at both region words
	assign lo_hit = (at_r0 || at_r1) ? region_class(word_data[7:0]) : 3'b000;
	// high byte only at the first one
	assign hi_hit = at_r0 ? region_class(word_data[15:8]) : 3'b000;
	assign hit = lo_hit | hi_hit;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
			hdr_e     <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			// fresh load forgets old letters
			if (cart_begin) begin
				hdr_j <= 1'b0;
				hdr_u <= 1'b0;
				hdr_e <= 1'b0;
			end
			if (cart_end)
				hdr_ready <= 1'b0;
			if (cart_stb) begin
				// letters accumulate
				if (hit[2])
					hdr_j <= 1'b1;
				if (hit[1])
					hdr_u <= 1'b1;
				if (hit[0])
					hdr_e <= 1'b1;
				if (word_addr == `HDR_END_ADDR)
					hdr_ready <= 1'b1;
			end
		end
	end

endmodule

//--- hw/cart_quirk_table.sv
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module cart_quirk_table
	import cart_load_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    cart_stb,
	input  logic                    cart_begin,
	input  logic [`CL_ADDR_W-1:0]   word_addr,
	input  logic [`CL_DATA_W-1:0]   word_data,
	output logic [`QUIRK_W-1:0]     quirks,
	output gun_type_e               gun_type,
	output logic [`GUN_DELAY_W-1:0] gun_delay
);

	logic [63:0] cart_id;
	logic        at_decode;

	assign at_decode = cart_stb && (word_addr == `HDR_ID_DECODE_ADDR);

	////////////////////////////////////////////////////////////
	// product id gather
	////////////////////////////////////////////////////////////
	// first and last words give one byte, middle words two
	always_ff @(posedge clk_sys) begin
		if (cart_stb) begin
			case (word_addr)
				`HDR_ID_ADDR_0: cart_id[63:56] <= word_data[15:8];
				`HDR_ID_ADDR_1: cart_id[55:40] <= {word_data[7:0], word_data[15:8]};
				`HDR_ID_ADDR_2: cart_id[39:24] <= {word_data[7:0], word_data[15:8]};
				`HDR_ID_ADDR_3: cart_id[23:8]  <= {word_data[7:0], word_data[15:8]};
				`HDR_ID_ADDR_4: cart_id[7:0]   <= word_data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// quirk and light gun decode
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			quirks    <= '0;
			gun_type  <= GUN_MENACER;
			gun_delay <= `GUN_DELAY_DEFAULT;
		end else begin
			if (cart_begin)
				quirks <= '0;
			if (at_decode) begin
				// at most one flag per title
				case (cart_id)
					`ID_NFL_QB_CLUB, `ID_NBA_JAM_TE: quirks[QK_SRAM] <= 1'b1;
					`ID_HOLYFIELD, `ID_WONDER_BOY:   quirks[QK_EEPROM] <= 1'b1;
					`ID_CLUE:                        quirks[QK_FIFO] <= 1'b1;
					// fake ram check in the game
					`ID_PUGGSY:                      quirks[QK_NORAM] <= 1'b1;
					`ID_PIER_SOLAR:                  quirks[QK_PIER] <= 1'b1;
					`ID_VIRTUA_RACING:               quirks[QK_SVP] <= 1'b1;
					`ID_HELLFIRE:                    quirks[QK_FMBUSY] <= 1'b1;
					`ID_KANZUME:                     quirks[QK_SCHAN] <= 1'b1;
					default: ;
				endcase
				// gun settings always reload, unknown titles get the menacer default
				case (cart_id)
					`ID_BODY_COUNT: begin
						gun_type  <= GUN_MENACER;
						gun_delay <= `GUN_DELAY_BODY_COUNT;
					end
					`ID_LETHAL_1: begin
						gun_type  <= GUN_JUSTIFIER;
						gun_delay <= `GUN_DELAY_LETHAL_1;
					end
					`ID_LETHAL_2: begin
						gun_type  <= GUN_JUSTIFIER;
						gun_delay <= `GUN_DELAY_LETHAL_2;
					end
					default: begin
						gun_type  <= GUN_MENACER;
						gun_delay <= `GUN_DELAY_DEFAULT;
					end
				endcase
			end
		end
	end

endmodule

//--- hw/cheat_code_assembler.sv
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module cheat_code_assembler (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   code_stb,
	input  logic [`CL_ADDR_W-1:0]  word_addr,
	input  logic [`CL_DATA_W-1:0]  word_data,
	output logic [`CHEAT_W-2:0]    cheat_code,
	output logic                   cheat_valid,
	output logic                   cheat_reset
);

	logic [3:0] slot;

	// byte offset inside one 16 byte code
	assign slot = word_addr[3:0];

	////////////////////////////////////////////////////////////
	// record layout
	// flags 127:96, address 95:64, compare 63:32, replace 31:0
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (code_stb) begin
			case (slot)
				4'd0:  cheat_code[111:96]  <= word_data;
				4'd2:  cheat_code[127:112] <= word_data;
				4'd4:  cheat_code[79:64]   <= word_data;
				4'd6:  cheat_code[95:80]   <= word_data;
				4'd8:  cheat_code[47:32]   <= word_data;
				4'd10: cheat_code[63:48]   <= word_data;
				4'd12: cheat_code[15:0]    <= word_data;
				4'd14: cheat_code[31:16]   <= word_data;
				// odd offsets carry nothing
				default: ;
			endcase
		end
	end

	// strobes
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			// last word of a record clocks it out
			cheat_valid <= code_stb && (slot == 4'd14);
			// a load starting at zero wipes the code list
			cheat_reset <= code_stb && (word_addr == '0);
		end
	end

endmodule

//--- hw/cart_load_top.sv
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module cart_load_top
	import cart_load_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	// loader
	input  logic                    load_active,
	input  logic                    load_is_code,
	input  logic                    load_valid,
	output logic                    load_ready,
	input  logic [`CL_ADDR_W-1:0]   load_addr,
	input  logic [`CL_DATA_W-1:0]   load_data,
	// external memory
	output logic                    mem_req,
	input  logic                    mem_ack,
	output logic [`CL_ADDR_W-2:0]   mem_addr,
	output logic [`CL_DATA_W-1:0]   mem_data,
	// header region
	output logic                    hdr_j,
	output logic                    hdr_u,
	output logic                    hdr_e,
	output logic                    hdr_ready,
	// quirks and light gun
	output logic [`QUIRK_W-1:0]     quirks,
	output gun_type_e               gun_type,
	output logic [`GUN_DELAY_W-1:0] gun_delay,
	// cheat codes
	output logic [`CHEAT_W-2:0]     cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_reset
);

	// snoop bus from the bridge
	logic                  cart_stb;
	logic                  code_stb;
	logic [`CL_ADDR_W-1:0] word_addr;
	logic [`CL_DATA_W-1:0] word_data;
	logic                  cart_begin;
	logic                  cart_end;

	rom_load_bridge u_bridge (
		.clk_sys, .rst_n,
		.load_active, .load_is_code, .load_valid, .load_ready, .load_addr, .load_data,
		.mem_req, .mem_ack, .mem_addr, .mem_data,
		.cart_stb, .code_stb, .word_addr, .word_data, .cart_begin, .cart_end
	);

	header_region_scan u_region (
		.clk_sys, .rst_n,
		.cart_stb, .cart_begin, .cart_end, .word_addr, .word_data,
		.hdr_j, .hdr_u, .hdr_e, .hdr_ready
	);

	cart_quirk_table u_quirks (
		.clk_sys, .rst_n,
		.cart_stb, .cart_begin, .word_addr, .word_data,
		.quirks, .gun_type, .gun_delay
	);

	cheat_code_assembler u_cheat (
		.clk_sys, .rst_n,
		.code_stb, .word_addr, .word_data,
		.cheat_code, .cheat_valid, .cheat_reset
	);

endmodule

//--- verif/cart_load_model.svh
`ifndef CART_LOAD_MODEL_SVH
`define CART_LOAD_MODEL_SVH

`include "cart_load_defines.svh"

////////////////////////////////////////////////////////////
// reference model included inside the testbench module
////////////////////////////////////////////////////////////

// one image covers the header and a few words past its end
localparam int CART_WORDS = 264;
localparam int N_TITLES   = 14;
localparam int REGION_W0  = `HDR_REGION_ADDR_0 / 2;
localparam int REGION_W1  = `HDR_REGION_ADDR_1 / 2;

logic [15:0]              cart_img    [CART_WORDS];
logic [63:0]              title_id    [N_TITLES];
logic [`QUIRK_W-1:0]      title_quirk [N_TITLES];
gun_type_e                title_gun   [N_TITLES];
logic [`GUN_DELAY_W-1:0]  title_delay [N_TITLES];
// letters, digits and a few bytes outside the region range
logic [7:0]               region_char [8];

// memory holds each loader word with its bytes swapped
function automatic logic [15:0] swap_bytes(input logic [15:0] w);
	return {w[7:0], w[15:8]};
endfunction

// expected {j, u, e} from the three region bytes that count
function automatic logic [2:0] region_rule(input logic [23:0] bytes);
	logic [2:0] flags;
	logic [7:0] b;
	flags = 3'b000;
	for (int k = 0; k < 3; k++) begin
		b = bytes[k*8 +: 8];
		if (b == "J")
			flags[2] = 1'b1;
		else if (b == "U")
			flags[1] = 1'b1;
		else if (b >= "0" && b <= "Z")
			flags[0] = 1'b1;
	end
	return flags;
endfunction

// record order is flags, address, compare, replace
function automatic logic [127:0] pack_cheat(input logic [15:0] w [8]);
	return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
endfunction

task automatic set_title(input int idx, input logic [63:0] id, input logic [7:0] q,
		input gun_type_e g, input logic [7:0] d);
	title_id[idx]    = id;
	title_quirk[idx] = q;
	title_gun[idx]   = g;
	title_delay[idx] = d;
endtask

task automatic fill_tables();
	set_title(0, `ID_NFL_QB_CLUB, 8'h01 << QK_SRAM, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(1, `ID_NBA_JAM_TE, 8'h01 << QK_SRAM, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(2, `ID_HOLYFIELD, 8'h01 << QK_EEPROM, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(3, `ID_WONDER_BOY, 8'h01 << QK_EEPROM, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(4, `ID_PUGGSY, 8'h01 << QK_NORAM, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(5, `ID_CLUE, 8'h01 << QK_FIFO, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(6, `ID_PIER_SOLAR, 8'h01 << QK_PIER, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(7, `ID_VIRTUA_RACING, 8'h01 << QK_SVP, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(8, `ID_HELLFIRE, 8'h01 << QK_FMBUSY, GUN_MENACER, `GUN_DELAY_DEFAULT);
	set_title(9, `ID_KANZUME, 8'h01 << QK_SCHAN, GUN_MENACER, `GUN_DELAY_DEFAULT);
	// gun titles carry no quirk flag
	set_title(10, `ID_BODY_COUNT, 8'h00, GUN_MENACER, `GUN_DELAY_BODY_COUNT);
	set_title(11, `ID_LETHAL_1, 8'h00, GUN_JUSTIFIER, `GUN_DELAY_LETHAL_1);
	set_title(12, `ID_LETHAL_2, 8'h00, GUN_JUSTIFIER, `GUN_DELAY_LETHAL_2);
	// unknown id goes last so the defaults must come back
	set_title(13, "ZZ-00000", 8'h00, GUN_MENACER, `GUN_DELAY_DEFAULT);
	region_char = '{"J", "U", "E", "A", "4", " ", "a", "~"};
endtask

// first word high byte, three swapped pairs, last word low byte
task automatic plant_id(input logic [63:0] id);
	cart_img[int'(`HDR_ID_ADDR_0 / 2)][15:8] = id[63:56];
	cart_img[int'(`HDR_ID_ADDR_1 / 2)] = {id[47:40], id[55:48]};
	cart_img[int'(`HDR_ID_ADDR_2 / 2)] = {id[31:24], id[39:32]};
	cart_img[int'(`HDR_ID_ADDR_3 / 2)] = {id[15:8], id[23:16]};
	cart_img[int'(`HDR_ID_ADDR_4 / 2)][7:0] = id[7:0];
endtask

`endif

//--- verif/tb_cart_load.sv
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module tb_cart_load
	import cart_load_pkg::*;
();

	typedef logic [`CL_ADDR_W-1:0] addr_t;
	typedef logic [`CL_ADDR_W-2:0] mem_addr_t;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    load_active;
	logic                    load_is_code;
	logic                    load_valid;
	logic                    load_ready;
	addr_t                   load_addr;
	logic [`CL_DATA_W-1:0]   load_data;
	logic                    mem_req;
	logic                    mem_ack = 1'b0;
	mem_addr_t               mem_addr;
	logic [`CL_DATA_W-1:0]   mem_data;
	logic                    hdr_j;
	logic                    hdr_u;
	logic                    hdr_e;
	logic                    hdr_ready;
	logic [`QUIRK_W-1:0]     quirks;
	gun_type_e               gun_type;
	logic [`GUN_DELAY_W-1:0] gun_delay;
	logic [`CHEAT_W-2:0]     cheat_code;
	logic                    cheat_valid;
	logic                    cheat_reset;

	`include "cart_load_model.svh"

	localparam int CLK_PERIOD   = 20;
	// every title image plus one cheat record
	localparam int N_WORDS      = N_TITLES * CART_WORDS + 8;
	localparam int WATCH_CYCLES = N_WORDS * 10 + 2000;

	integer              seed = 32'h9509_7626;
	int                  err_cnt = 0;
	int                  wr_total = 0;
	int                  valid_cnt = 0;
	int                  reset_cnt = 0;
	logic [`CHEAT_W-2:0] got_code;
	int                  ack_wait;
	bit                  ack_busy;
	mem_addr_t           wr_addr_q [$];
	logic [15:0]         wr_data_q [$];

	cart_load_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// memory responder and strobe monitor
	////////////////////////////////////////////////////////////
	// each write completes 0 to 7 cycles after it shows up
	always @(posedge clk_sys) begin
		if (rst_n) begin
			if (!ack_busy && (mem_req != mem_ack)) begin
				ack_busy = 1'b1;
				ack_wait = {$random(seed)} % 8;
			end
			if (ack_busy) begin
				if (ack_wait == 0) begin
					wr_addr_q.push_back(mem_addr);
					wr_data_q.push_back(mem_data);
					mem_ack <= ~mem_ack;
					ack_busy = 1'b0;
				end else begin
					ack_wait = ack_wait - 1;
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		if (rst_n && cheat_valid) begin
			valid_cnt <= valid_cnt + 1;
			got_code  <= cheat_code;
		end
		if (rst_n && cheat_reset)
			reset_cnt <= reset_cnt + 1;
	end

	task automatic report_error(input string msg);
		err_cnt++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	// random idle gap, then hold the word until ready is seen
	task automatic send_word(input int addr, input logic [15:0] data);
		int gap;
		gap = {$random(seed)} % 3;
		if (gap > 0) begin
			load_valid <= 1'b0;
			repeat (gap) @(posedge clk_sys);
		end
		load_valid <= 1'b1;
		load_addr  <= addr_t'(addr);
		load_data  <= data;
		@(posedge clk_sys);
		while (!load_ready)
			@(posedge clk_sys);
	endtask

	// last write acknowledged and the bridge back in idle
	task automatic wait_idle();
		load_valid <= 1'b0;
		@(posedge clk_sys);
		while (!load_ready)
			@(posedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// one cartridge load per table entry
	////////////////////////////////////////////////////////////
	task automatic load_title(input int idx);
		logic [15:0] r0;
		logic [15:0] r1;
		logic [2:0]  exp_reg;
		for (int i = 0; i < CART_WORDS; i++)
			cart_img[i] = 16'($random(seed));
		plant_id(title_id[idx]);
		// high byte of the second region word must be ignored
		r0 = {region_char[3'($random(seed))], region_char[3'($random(seed))]};
		r1 = {8'($random(seed)), region_char[3'($random(seed))]};
		cart_img[REGION_W0] = r0;
		cart_img[REGION_W1] = r1;
		exp_reg = region_rule({r0[7:0], r0[15:8], r1[7:0]});
		wr_addr_q.delete();
		wr_data_q.delete();
		load_is_code <= 1'b0;
		load_active  <= 1'b1;
		for (int i = 0; i < CART_WORDS; i++)
			send_word(2 * i, cart_img[i]);
		wait_idle();
		wr_total += wr_addr_q.size();
		if (wr_addr_q.size() != CART_WORDS) begin
			report_error($sformatf("title %0d: %0d writes for %0d words", idx,
				wr_addr_q.size(), CART_WORDS));
		end else begin
			for (int i = 0; i < CART_WORDS; i++) begin
				if (wr_addr_q[i] != mem_addr_t'(i) || wr_data_q[i] != swap_bytes(cart_img[i]))
					report_error($sformatf("write %0d: got %h/%h, want %h/%h", i,
						wr_addr_q[i], wr_data_q[i], i, swap_bytes(cart_img[i])));
			end
		end
		if ({hdr_j, hdr_u, hdr_e} != exp_reg || !hdr_ready)
			report_error($sformatf("title %0d: region %b ready %b, want %b ready 1", idx,
				{hdr_j, hdr_u, hdr_e}, hdr_ready, exp_reg));
		if (quirks != title_quirk[idx] || gun_type != title_gun[idx]
				|| gun_delay != title_delay[idx])
			report_error($sformatf("title %0d: quirks %h gun %0d delay %0d, want %h %0d %0d",
				idx, quirks, gun_type, gun_delay, title_quirk[idx], title_gun[idx],
				title_delay[idx]));
		// end pulse follows one cycle later, the flag one more
		load_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
		if (hdr_ready)
			report_error($sformatf("title %0d: hdr_ready still set after load end", idx));
	endtask

	// eight code words make one record starting at address 0
	task automatic load_cheat();
		logic [15:0] w [8];
		int          writes_before;
		logic        req_before;
		writes_before = wr_addr_q.size();
		req_before = mem_req;
		for (int k = 0; k < 8; k++)
			w[k] = 16'($random(seed));
		load_is_code <= 1'b1;
		load_active  <= 1'b1;
		for (int k = 0; k < 8; k++)
			send_word(2 * k, w[k]);
		load_valid <= 1'b0;
		repeat (4) @(posedge clk_sys);
		load_active <= 1'b0;
		if (valid_cnt != 1 || reset_cnt != 1)
			report_error($sformatf("cheat: %0d valid and %0d reset pulses, want 1 and 1",
				valid_cnt, reset_cnt));
		if (got_code != pack_cheat(w))
			report_error($sformatf("cheat: code %h, want %h", got_code, pack_cheat(w)));
		if (wr_addr_q.size() != writes_before || mem_req != req_before)
			report_error("cheat: memory write issued during a code load");
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		rst_n        <= 1'b0;
		load_active  <= 1'b0;
		load_is_code <= 1'b0;
		load_valid   <= 1'b0;
		load_addr    <= '0;
		load_data    <= '0;
		fill_tables();
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);
		if (!load_ready || mem_req || hdr_ready || hdr_j || hdr_u || hdr_e)
			report_error("reset: bridge or header flags not at reset value");
		if (cheat_valid || cheat_reset || quirks != '0)
			report_error("reset: cheat strobes or quirk flags not low");
		if (gun_type != GUN_MENACER || gun_delay != 8'd44)
			report_error($sformatf("reset: gun %0d delay %0d", gun_type, gun_delay));
		for (int t = 0; t < N_TITLES; t++)
			load_title(t);
		load_cheat();
		$display("writes checked: %0d, cheat records: %0d, errors: %0d",
			wr_total, valid_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// loads stall forever if the handshake breaks
	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+hw
+incdir+verif
hw/cart_load_pkg.sv
hw/rom_load_bridge.sv
hw/header_region_scan.sv
hw/cart_quirk_table.sv
hw/cheat_code_assembler.sv
hw/cart_load_top.sv
verif/tb_cart_load.sv

//--- Makefile
# Verilator simulation of the cartridge load front end

BUILD := build
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build outputs and the log"

$(BUILD)/tb_cart_load: sources.f $(wildcard hw/*.sv hw/*.svh verif/*.sv verif/*.svh)
	verilator --binary --timing --assert --top-module tb_cart_load \
		-f sources.f -Mdir $(BUILD) -o tb_cart_load

test: $(BUILD)/tb_cart_load
	-$(BUILD)/tb_cart_load > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
